// ==== s100SbcTop.f ====
+incdir+tests
source/s100BusPkg.sv
source/busCycleSequencer.sv
source/busLatch.sv
source/addressDecoder.sv
source/waitStateGen.sv
source/frontPanelPort.sv
source/s100SbcTop.sv
tests/s100SbcTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the S-100 SBC testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f s100SbcTop.f --top-module s100SbcTb \
    -Mdir obj_dir -o s100SbcSim

./obj_dir/s100SbcSim | tee "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/s100SbcTests.svh ====
/*
 * Z80 bus driver and directed tests for the S-100 SBC glue,
 * included into the testbench module
 */
`ifndef S100_SBC_TESTS_SVH
`define S100_SBC_TESTS_SVH

logic curMem;                                     // cycle in progress
logic curRead;
int   xrdyHold;                                   // edges xrdy stays low

// status the bus should show for a cycle kind
function automatic status_t expectedStatus(input logic isMem, input logic isRead);
    status_t s;
    s       = '0;                                 // no halt, m1 or int ack
    s.nSwo  = isRead;                             // low on any write
    s.sMemr = isMem && isRead;
    s.sInp  = !isMem && isRead;
    s.sOut  = !isMem && !isRead;
    return s;
endfunction

task automatic releasePins();
    nMreq <= 1'b1;
    nIorq <= 1'b1;
    nRd   <= 1'b1;
    nWr   <= 1'b1;
endtask

// drive a request, returns at the falling edge after E0
task automatic startCycle(input logic isMem, input logic isRead, input addr_t addr,
                          input data_t data, input int xrdyCycles);
    @(posedge pll0_2MHz);
    nMreq      <= !isMem;
    nIorq      <= isMem;
    nRd        <= !isRead;
    nWr        <= isRead;
    cpuAddress <= addr;
    cpuDataOut <= data;
    s100Di     <= 8'($urandom);
    biDataIn   <= 8'($urandom);
    if (xrdyCycles > 0) xrdy <= 1'b0;             // external not ready
    curMem   = isMem;
    curRead  = isRead;
    xrdyHold = xrdyCycles;
    @(posedge pll0_2MHz);                         // E0
    @(negedge pll0_2MHz);
    checkBit("pSync", pSync, 1'b1);
    checkBit("pStval", pStval, 1'b1);
    checkAddr("s100Address", s100Address, isMem ? addr : {8'h00, addr[7:0]});
    checkStatus("status", latchedStatus(), expectedStatus(isMem, isRead));
endtask

// hold the pins until nWait is seen high from E2 on, count wait cycles
task automatic finishCycle(output int lowCount);
    int   edgeNum;
    logic waitSeen;
    logic done;
    lowCount = 0;
    edgeNum  = 0;
    done     = 1'b0;
    while (!done) begin
        waitSeen = nWait;
        if (!nWait) lowCount++;
        if (!xrdy) checkBit("nWait", nWait, 1'b0); // stretched by xrdy
        if (edgeNum == 1) begin
            checkBit("pSync", pSync, 1'b0);
            checkBit("pStval", pStval, 1'b0);
        end
        if (edgeNum >= 1) begin
            checkBit("pDbin", pDbin, curRead);
            checkBit("nPwr", nPwr, curRead);      // low on writes
            checkBit("sMwrt", sMwrt, curMem && !curRead);
        end
        @(posedge pll0_2MHz);
        edgeNum++;
        if (edgeNum == xrdyHold) xrdy <= 1'b1;
        if (edgeNum >= 2 && waitSeen) begin
            releasePins();
            done = 1'b1;
        end else begin
            @(negedge pll0_2MHz);
        end
    end
    @(posedge pll0_2MHz);                         // request seen gone
    @(negedge pll0_2MHz);
    checkBit("pDbin", pDbin, 1'b0);
    checkBit("nPwr", nPwr, 1'b1);
endtask

//////////////////////////////
// directed tests
//////////////////////////////
task automatic resetValues();
    @(negedge pll0_2MHz);
    checkBit("pSync", pSync, 1'b0);
    checkBit("pStval", pStval, 1'b1);
    checkBit("pDbin", pDbin, 1'b0);
    checkBit("nPwr", nPwr, 1'b1);
    checkBit("nWait", nWait, 1'b1);
    checkStatus("status", latchedStatus(), '0);
    checkAddr("s100Address", s100Address, '0);
    checkData("sbcLeds", sbcLeds, 8'hFF);         // empty port, bar dark
endtask

task automatic offBoardRead();
    int lows;
    startCycle(1'b1, 1'b1, {1'b1, 15'($urandom)}, '0, 0);
    checkData("cpuDataIn", cpuDataIn, s100Di);
    finishCycle(lows);
    checkCount("nWait low cycles", lows, 0);
endtask

task automatic ramWriteRead();
    addr_t addr;
    data_t data;
    int    lows;
    addr = {1'b0, 15'($urandom)};                 // inside the window
    data = 8'($urandom);
    startCycle(1'b1, 1'b0, addr, data, 0);
    checkBit("ramNCs", ramNCs, 1'b0);
    checkBit("ramNWr", ramNWr, 1'b0);
    checkBit("biDataOe", biDataOe, 1'b1);
    checkData("biDataOut", biDataOut, data);
    finishCycle(lows);
    checkCount("nWait low cycles", lows, int'(ramWaits));
    startCycle(1'b1, 1'b1, addr, '0, 0);
    checkBit("ramNOe", ramNOe, 1'b0);
    checkData("cpuDataIn", cpuDataIn, biDataIn);
    finishCycle(lows);
    checkCount("nWait low cycles", lows, int'(ramWaits));
endtask

task automatic portWrite();
    data_t data;
    int    lows;
    data = 8'($urandom);
    startCycle(1'b0, 1'b0, {8'($urandom), frontPanelPort}, data, 0);
    checkData("s100Do", s100Do, data);
    finishCycle(lows);
    checkCount("nWait low cycles", lows, int'(ioWaits));
    checkData("sbcLeds", sbcLeds, ~data);
    startCycle(1'b0, 1'b0, {8'($urandom), 8'($urandom % 255)}, ~data, 0);
    finishCycle(lows);
    checkData("sbcLeds", sbcLeds, ~data);         // other port, latch kept
endtask

task automatic ioReadNotReady();
    int hold;
    int lows;
    hold = 1 + int'($urandom % 4);
    startCycle(1'b0, 1'b1, {8'($urandom), 8'($urandom)}, '0, hold);
    checkData("cpuDataIn", cpuDataIn, s100Di);
    finishCycle(lows);
    checkCount("nWait low cycles", lows, (hold > int'(ioWaits)) ? hold : int'(ioWaits));
endtask

task automatic ledSources();
    data_t data;
    data_t debugExp;
    int    lows;
    data = 8'($urandom);
    @(posedge pll0_2MHz);
    ioByte <= cpuOut;
    startCycle(1'b1, 1'b0, {1'b1, 15'($urandom)}, data, 0);
    checkData("sbcLeds", sbcLeds, ~data);
    finishCycle(lows);
    @(posedge pll0_2MHz);
    ioByte <= cpuIn;
    startCycle(1'b1, 1'b1, {1'b1, 15'($urandom)}, '0, 0);
    checkData("sbcLeds", sbcLeds, ~s100Di);       // off board, data from s100
    finishCycle(lows);
    @(posedge pll0_2MHz);
    ioByte <= debug;
    startCycle(1'b1, 1'b1, {1'b1, 15'($urandom)}, '0, 0);
    debugExp[0] = 1'b0;                           // ramCs, off board
    debugExp[1] = 1'b0;                           // nRd held
    debugExp[2] = 1'b0;                           // nMreq held
    debugExp[3] = 1'b1;                           // pSync, first cycle
    debugExp[4] = 1'b0;                           // pDbin opens at E1
    debugExp[5] = 1'b1;                           // sMemr latched
    debugExp[6] = 1'b0;                           // sInp
    debugExp[7] = 1'b0;                           // sOut
    checkData("sbcLeds", sbcLeds, ~debugExp);
    finishCycle(lows);
    @(posedge pll0_2MHz);
    ioByte <= portFF;
endtask

`endif

// ==== tests/s100SbcTb.sv ====
/*
 * S-100 SBC glue testbench
 * plays the Z80 on the cpu pins, runs the directed bus cycle tests,
 * counts mismatches and reports the result
 */
`timescale 1ns/1ps

module s100SbcTb
    import s100BusPkg::*;
();

    localparam int expectedCycles = 200;          // all tests together, roughly
    localparam int cycleLimit     = 10 * expectedCycles;

    logic       pll0_2MHz;
    logic       n_reset;
    logic       nMreq, nIorq, nRd, nWr, nM1, nRfsh, nHalt;
    addr_t      cpuAddress;
    data_t      cpuDataOut;
    data_t      s100Di;
    data_t      biDataIn;
    logic       xrdy, rdy;
    logic [7:6] ioByte;                           // led source switches

    data_t      cpuDataIn, s100Do, biDataOut, sbcLeds;
    addr_t      s100Address;
    logic       nWait;
    logic       sHlta, sOut, sInp, sMemr, nSwo, sM1, sInta;
    logic       pSync, pStval, pDbin, nPwr, sMwrt;
    logic       ramNCs, ramNOe, ramNWr, biDataOe;

    int mismatchCount = 0;
    int checksRun     = 0;
    int cycleCount    = 0;

    s100SbcTop s100SbcTop_inst (.*);

    initial begin
        pll0_2MHz = 1'b0;
        forever #4 pll0_2MHz = ~pll0_2MHz;       // 8 ns period
    end

    // run limit, ten times the expected test length
    always @(posedge pll0_2MHz) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: tests still running after %0d cycles", cycleCount);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic checkBit(input string name, input logic got, input logic exp);
        checksRun++;
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkData(input string name, input data_t got, input data_t exp);
        checksRun++;
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
        checksRun++;
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkStatus(input string name, input status_t got, input status_t exp);
        checksRun++;
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        checksRun++;
        if (got != exp) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // status pins gathered into one word
    function automatic status_t latchedStatus();
        status_t s;
        s.sHlta = sHlta;
        s.sOut  = sOut;
        s.sInp  = sInp;
        s.sMemr = sMemr;
        s.nSwo  = nSwo;
        s.sM1   = sM1;
        s.sInta = sInta;
        return s;
    endfunction

    `include "s100SbcTests.svh"

    initial begin
        void'($urandom(98420));                   // one seed for the run
        n_reset    <= 1'b0;
        {nMreq, nIorq, nRd, nWr}  <= 4'hF;        // bus idle
        {nM1, nRfsh, nHalt}       <= 3'h7;
        cpuAddress <= '0;
        cpuDataOut <= '0;
        s100Di     <= '0;
        biDataIn   <= '0;
        xrdy       <= 1'b1;
        rdy        <= 1'b1;
        ioByte     <= portFF;
        repeat (2) @(posedge pll0_2MHz);
        n_reset    <= 1'b1;

        resetValues();
        offBoardRead();
        ramWriteRead();
        portWrite();
        ioReadNotReady();
        ledSources();

        $display("%0d checks run, %0d mismatches", checksRun, mismatchCount);
        if (mismatchCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== source/s100SbcTop.sv ====
/*
 * S-100 SBC bus glue, top level
 * ties the Z80 pin bus to the IEEE-696 bus: cycle sequencer, status
 * and address latches, decoder, wait state generator and the front
 * panel port with LED bar
 */
`timescale 1ns/1ps

module s100SbcTop
    import s100BusPkg::*;
(
    input  logic       pll0_2MHz,
    input  logic       n_reset,
    // cpu side
    input  logic       nMreq,
    input  logic       nIorq,
    input  logic       nRd,
    input  logic       nWr,
    input  logic       nM1,
    input  logic       nRfsh,
    input  logic       nHalt,
    input  addr_t      cpuAddress,
    input  data_t      cpuDataOut,
    output data_t      cpuDataIn,
    output logic       nWait,
    // s100 side
    input  data_t      s100Di,
    input  logic       xrdy,
    input  logic       rdy,
    output data_t      s100Do,
    output addr_t      s100Address,
    output logic       sHlta,
    output logic       sOut,
    output logic       sInp,
    output logic       sMemr,
    output logic       nSwo,
    output logic       sM1,
    output logic       sInta,
    output logic       pSync,
    output logic       pStval,
    output logic       pDbin,                     // positive pin here
    output logic       nPwr,
    output logic       sMwrt,
    // onboard ram
    input  data_t      biDataIn,
    output logic       ramNCs,
    output logic       ramNOe,
    output logic       ramNWr,
    output data_t      biDataOut,
    output logic       biDataOe,
    // switches and leds
    input  logic [7:6] ioByte,
    output data_t      sbcLeds
);

    logic    newCycle;                            // cycle start strobe
    logic    ramCs;
    logic    ioCycle;
    logic    portFFWr;
    status_t statusNow;                           // live, from the pins
    status_t statusQ;                             // latched for the bus
    addr_t   busAddress;
    ledSel_t ledSel;

    //////////////////////////////
    // pin wiring
    //////////////////////////////
    assign s100Do    = cpuDataOut;
    assign biDataOut = cpuDataOut;
    assign ledSel    = ledSel_t'(ioByte);
    assign sHlta     = statusQ.sHlta;
    assign sOut      = statusQ.sOut;
    assign sInp      = statusQ.sInp;
    assign sMemr     = statusQ.sMemr;
    assign nSwo      = statusQ.nSwo;
    assign sM1       = statusQ.sM1;
    assign sInta     = statusQ.sInta;

    //////////////////////////////
    // blocks
    //////////////////////////////
    busCycleSequencer sequencer (
        .pll0_2MHz(pll0_2MHz), .n_reset(n_reset),
        .nMreq(nMreq), .nIorq(nIorq), .nRd(nRd), .nWr(nWr), .nRfsh(nRfsh),
        .newCycle(newCycle), .pSync(pSync), .pStval(pStval),
        .pDbin(pDbin), .nPwr(nPwr), .sMwrt(sMwrt)
    );

    busLatch #(.payload_t(status_t)) statusLatch (
        .pll0_2MHz(pll0_2MHz), .n_reset(n_reset),
        .load(newCycle), .d(statusNow), .q(statusQ)
    );

    busLatch #(.payload_t(addr_t)) addressLatch (
        .pll0_2MHz(pll0_2MHz), .n_reset(n_reset),
        .load(newCycle), .d(busAddress), .q(s100Address)
    );

    addressDecoder decoder (
        .nMreq(nMreq), .nIorq(nIorq), .nRd(nRd), .nWr(nWr),
        .nM1(nM1), .nRfsh(nRfsh), .nHalt(nHalt),
        .cpuAddress(cpuAddress), .biDataIn(biDataIn), .s100Di(s100Di),
        .ramCs(ramCs), .ioCycle(ioCycle), .portFFWr(portFFWr),
        .ramNCs(ramNCs), .ramNOe(ramNOe), .ramNWr(ramNWr), .biDataOe(biDataOe),
        .statusNow(statusNow), .busAddress(busAddress), .cpuDataIn(cpuDataIn)
    );

    waitStateGen waitGen (
        .pll0_2MHz(pll0_2MHz), .n_reset(n_reset), .newCycle(newCycle),
        .ramCs(ramCs), .ioCycle(ioCycle), .xrdy(xrdy), .rdy(rdy),
        .nWait(nWait)
    );

    frontPanelPort panel (
        .pll0_2MHz(pll0_2MHz), .n_reset(n_reset), .newCycle(newCycle),
        .portFFWr(portFFWr), .pDbin(pDbin), .pSync(pSync), .ramCs(ramCs),
        .nRd(nRd), .nMreq(nMreq),
        .cpuDataOut(cpuDataOut), .cpuDataIn(cpuDataIn),
        .sMemr(statusQ.sMemr), .sInp(statusQ.sInp), .sOut(statusQ.sOut),
        .ledSel(ledSel), .sbcLeds(sbcLeds)
    );

endmodule

// ==== source/frontPanelPort.sv ====
/*
 * Front panel port
 * output port 0xFF latch and the onboard LED bar, the bar shows one of
 * cpu data out, cpu data in, a debug byte or the port latch, inverted
 * since the LEDs light on a low
 */
`timescale 1ns/1ps

module frontPanelPort
    import s100BusPkg::*;
(
    input  logic    pll0_2MHz,
    input  logic    n_reset,
    input  logic    newCycle,                     // high into E0
    input  logic    portFFWr,                     // out (0FFh) decode
    input  logic    pDbin,
    input  logic    pSync,
    input  logic    ramCs,
    input  logic    nRd,
    input  logic    nMreq,
    input  data_t   cpuDataOut,
    input  data_t   cpuDataIn,
    input  logic    sMemr,                        // latched status bits
    input  logic    sInp,
    input  logic    sOut,
    input  ledSel_t ledSel,                       // iobyte switches 7:6
    output data_t   sbcLeds
);

    data_t portReg;                               // port 255 contents
    data_t debugByte;
    data_t ledSource;

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            portReg <= '0;
        end else if (newCycle && portFFWr) begin
            portReg <= cpuDataOut;                // data valid at E0
        end
    end

    // quick look at the bus handshake
    assign debugByte = {sOut, sInp, sMemr, pDbin, pSync, nMreq, nRd, ramCs};

    always_comb begin
        case (ledSel)
            cpuOut:  ledSource = cpuDataOut;
            cpuIn:   ledSource = cpuDataIn;
            debug:   ledSource = debugByte;
            default: ledSource = portReg;         // portFF
        endcase
    end

    assign sbcLeds = ~ledSource;                  // active low bar

endmodule

// ==== source/waitStateGen.sv ====
/*
 * Wait state generator
 * down counter loaded at every cycle start with the onboard RAM or io
 * wait count, holds the cpu wait line low while it runs and while the
 * bus xrdy or rdy lines report not ready
 */
`timescale 1ns/1ps

module waitStateGen
    import s100BusPkg::*;
(
    input  logic pll0_2MHz,
    input  logic n_reset,
    input  logic newCycle,                        // high into E0
    input  logic ramCs,
    input  logic ioCycle,
    input  logic xrdy,                            // s100 pin 3
    input  logic rdy,                             // s100 pin 72
    output logic nWait                            // low stalls the cpu
);

    logic [waitCountWidth-1:0] waitCount;
    logic [waitCountWidth-1:0] loadValue;

    // count for the cycle now starting
    assign loadValue = ramCs   ? ramWaits :
                       ioCycle ? ioWaits  :
                                 '0;              // off board memory

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            waitCount <= '0;
        end else if (newCycle) begin
            waitCount <= loadValue;               // load at E0
        end else if (waitCount != '0) begin
            waitCount <= waitCount - 1'b1;        // one per clock
        end
    end

    assign nWait = (waitCount == '0) && xrdy && rdy;

    //////////////////////////////
    // a new cycle only starts once the previous waits ran out
    //////////////////////////////
    noReloadWhileBusy: assert property (
        @(posedge pll0_2MHz) disable iff (!n_reset)
        newCycle |-> (waitCount == '0)
    );

endmodule

// ==== source/addressDecoder.sv ====
/*
 * Address decoder
 * decodes the onboard RAM window and output port 0xFF from the cpu
 * pins, builds the live status word and bus address (high byte zero
 * on io), drives the RAM strobes and picks the cpu data-in source
 */
`timescale 1ns/1ps

module addressDecoder
    import s100BusPkg::*;
(
    input  logic    nMreq,                        // cpu pins, active low
    input  logic    nIorq,
    input  logic    nRd,
    input  logic    nWr,
    input  logic    nM1,
    input  logic    nRfsh,
    input  logic    nHalt,
    input  addr_t   cpuAddress,
    input  data_t   biDataIn,                     // onboard ram data
    input  data_t   s100Di,                       // s100 data in bus
    output logic    ramCs,
    output logic    ioCycle,
    output logic    portFFWr,
    output logic    ramNCs,
    output logic    ramNOe,
    output logic    ramNWr,
    output logic    biDataOe,
    output status_t statusNow,
    output addr_t   busAddress,
    output data_t   cpuDataIn
);

    logic memReq;                                 // mreq, not refresh
    logic ioReq;                                  // any iorq incl int ack
    logic memRd;
    logic memWr;

    assign memReq = !nMreq && nRfsh;
    assign ioReq  = !nIorq;
    assign memRd  = memReq && !nRd;
    assign memWr  = memReq && !nWr;

    //////////////////////////////
    // chip selects
    //////////////////////////////
    assign ramCs    = memReq && (cpuAddress[addrWidth-1:dataWidth] <= ramWindowTop);
    assign ioCycle  = ioReq && nM1;               // real io, not int ack
    assign portFFWr = ioCycle && !nWr && (cpuAddress[dataWidth-1:0] == frontPanelPort);

    // ram chip strobes, active low
    assign ramNCs   = !ramCs;
    assign ramNOe   = !(ramCs && memRd);
    assign ramNWr   = !(ramCs && memWr);
    assign biDataOe = ramCs && memWr;             // drive bidir bus on writes

    //////////////////////////////
    // status and address build
    //////////////////////////////
    always_comb begin
        statusNow.sHlta = !nHalt;
        statusNow.sOut  = ioCycle && !nWr;
        statusNow.sInp  = ioCycle && !nRd;
        statusNow.sMemr = memRd;
        statusNow.nSwo  = !(memWr || (ioCycle && !nWr)); // low on any write
        statusNow.sM1   = !nM1;
        statusNow.sInta = ioReq && !nM1;          // m1 with iorq
    end

    // z80 puts A/accumulator on A15-A8 during io, keep it off the bus
    assign busAddress = ioReq ? {8'h00, cpuAddress[dataWidth-1:0]} : cpuAddress;

    // data in mux
    assign cpuDataIn = ramCs ? biDataIn : s100Di;

endmodule

// ==== source/busLatch.sv ====
/*
 * Bus latch
 * load enabled register for one bus cycle, generic over its payload,
 * holds status or address steady from cycle start to the next start
 */
`timescale 1ns/1ps

module busLatch #(
    parameter type payload_t = logic [7:0]        // status word or address
) (
    input  logic     pll0_2MHz,
    input  logic     n_reset,
    input  logic     load,                        // cycle start strobe
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            q <= '0;                              // bus shows zero after reset
        end else if (load) begin
            q <= d;                               // capture at E0
        end
    end

endmodule

// ==== source/busCycleSequencer.sv ====
/*
 * Bus cycle sequencer
 * samples the Z80 request pins on the 2 MHz clock, flags the start of
 * each memory or io cycle (refresh ignored) and builds the IEEE-696
 * strobes pSync, pStval, pDbin, nPwr and sMwrt from it
 */
`timescale 1ns/1ps

module busCycleSequencer (
    input  logic pll0_2MHz,
    input  logic n_reset,
    input  logic nMreq,                           // cpu pins, active low
    input  logic nIorq,
    input  logic nRd,
    input  logic nWr,
    input  logic nRfsh,
    output logic newCycle,                        // high into E0
    output logic pSync,
    output logic pStval,
    output logic pDbin,
    output logic nPwr,
    output logic sMwrt
);

    logic memReq;                                 // mreq outside refresh
    logic live;                                   // request on the pins now
    logic reqQ;                                   // request seen last edge
    logic readNext;                               // pDbin next state
    logic writeNext;                              // write strobe next state

    //////////////////////////////
    // request detect
    //////////////////////////////
    assign memReq   = !nMreq && nRfsh;            // refresh is not a bus cycle
    assign live     = memReq || !nIorq;
    assign newCycle = live && !reqQ;              // rising side of request

    // data strobes open after the sync cycle, close once request is gone
    assign readNext  = (pSync || pDbin) && live && !nRd;
    assign writeNext = (pSync || !nPwr) && live && !nWr;

    //////////////////////////////
    // strobe registers
    //////////////////////////////
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            reqQ   <= 1'b0;
            pSync  <= 1'b0;                       // idle bus
            pStval <= 1'b1;                       // active low
            pDbin  <= 1'b0;
            nPwr   <= 1'b1;                       // active low
            sMwrt  <= 1'b0;
        end else begin
            reqQ   <= live;
            pSync  <= newCycle;                   // E0 to E1
            pStval <= !pSync;                     // low E1 to E2
            pDbin  <= readNext;
            nPwr   <= !writeNext;
            sMwrt  <= writeNext && memReq;        // memory writes only
        end
    end

    //////////////////////////////
    // protocol checks
    //////////////////////////////
    // read and write strobes never open in the same cycle
    strobesApart: assert property (
        @(posedge pll0_2MHz) disable iff (!n_reset)
        !(pDbin && !nPwr)
    );

endmodule

// ==== source/s100BusPkg.sv ====
/*
 * S-100 SBC bus package
 * widths, address and data types, the IEEE-696 status word,
 * LED source select, onboard RAM window, front panel port number
 * and the wait state counts shared by the bus glue
 */
package s100BusPkg;

    //////////////////////////////
    // bus widths and types
    //////////////////////////////
    localparam int addrWidth = 16;                // cpu and s100 address
    localparam int dataWidth = 8;                 // one byte data path

    typedef logic [addrWidth-1:0] addr_t;         // A15..A0
    typedef logic [dataWidth-1:0] data_t;         // D7..D0

    // status word, sHlta lands on bit 0 as on the latch chip
    typedef struct packed {
        logic sInta;                              // bit 6, int acknowledge
        logic sM1;                                // bit 5, opcode fetch
        logic nSwo;                               // bit 4, write out, active low
        logic sMemr;                              // bit 3, memory read
        logic sInp;                               // bit 2, io read
        logic sOut;                               // bit 1, io write
        logic sHlta;                              // bit 0, halt acknowledge
    } status_t;

    // led bar source, from the iobyte switches
    typedef enum logic [1:0] {
        cpuOut = 2'b00,                           // cpu data out bus
        cpuIn  = 2'b01,                           // cpu data in bus
        debug  = 2'b10,                           // debug byte
        portFF = 2'b11                            // front panel latch
    } ledSel_t;

    //////////////////////////////
    // decode and wait constants
    //////////////////////////////
    localparam logic [7:0] ramWindowTop   = 8'h7F; // 0000-7FFF onboard
    localparam logic [7:0] frontPanelPort = 8'hFF; // output port 255

    localparam int waitCountWidth = 2;            // wait counter bits
    localparam logic [waitCountWidth-1:0] ramWaits = 2'd2; // onboard ram
    localparam logic [waitCountWidth-1:0] ioWaits  = 2'd1; // any io cycle

endpackage
